// File: cpu_mem_sys.f
verilog/axi_pkg.sv
verilog/master_pkg.sv
verilog/axi_if.sv
verilog/axi_master.sv
verilog/axi_sram_slave.sv
verilog/cpu_mem_sys.sv
verification/tb_cpu_mem_sys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cpu_mem_sys testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cpu_mem_sys \
  -f cpu_mem_sys.f

./obj_dir/Vtb_cpu_mem_sys | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: verification/tb_cpu_mem_sys.sv
module tb_cpu_mem_sys
  import axi_pkg::*;
  import master_pkg::*;
();

  localparam int mem_words    = 256;
  localparam int accept_delay = 2;
  localparam int clk_period   = 20;
  localparam int read_bound   = accept_delay + 3;
  localparam int write_bound  = 2 * accept_delay + 4;
  localparam int max_requests = 400;

  logic                     clk = 1'b0;
  logic                     rstn;
  logic                     read;
  logic                     write;
  logic [axi_addr_bits-1:0] addr;
  logic [axi_data_bits-1:0] data_in;
  logic [axi_strb_bits-1:0] w_type;
  logic [axi_data_bits-1:0] data_out;
  logic                     stall;

  // Reference memory
  logic [axi_data_bits-1:0] ref_mem [mem_words];

  // Request taken last cycle and still in flight
  bit                       pend_valid;
  bit                       pend_read;
  logic [axi_data_bits-1:0] pend_exp;
  logic [axi_data_bits-1:0] last_rd;

  int seed = 66117;
  int check_count;
  int error_count;

  cpu_mem_sys #(
    .mem_words    (mem_words),
    .accept_delay (accept_delay)
  ) dut (
    .clk      (clk),
    .rstn     (rstn),
    .read     (read),
    .write    (write),
    .addr     (addr),
    .data_in  (data_in),
    .w_type   (w_type),
    .data_out (data_out),
    .stall    (stall)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    check_count++;
    assert (ok) else begin
      error_count++;
      $display("CHECK FAILED at %0t: %s", $time, what);
    end
  endtask

  function automatic int word_of(input logic [31:0] a);
    return int'(a[31:2]);
  endfunction

  // Unmapped words read as zero
  function automatic logic [31:0] model_read(input logic [31:0] a);
    if (word_of(a) >= mem_words) return '0;
    return ref_mem[word_of(a)];
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] strb);
    if (word_of(a) < mem_words) begin
      for (int i = 0; i < axi_strb_bits; i++) begin
        if (strb[i]) ref_mem[word_of(a)][8*i +: 8] = d[8*i +: 8];
      end
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9E3779B1) ^ 32'h5A5AA5A5;
  endfunction

  // Preloaded words are 0..23 and the top eight
  function automatic logic [31:0] slot_addr(input int j);
    int idx;
    idx = (j < 24) ? j : mem_words - 32 + j;
    return 32'(idx) << 2;
  endfunction

  // Drives one strobe (or none) and finishes the request already in flight
  task automatic run_step(input bit rd, input bit wr, input logic [31:0] a,
                          input logic [31:0] d, input logic [3:0] strb);
    int high_cycles;
    int bound;
    high_cycles = 0;
    bound = pend_read ? read_bound : write_bound;
    @(posedge clk);
    read    <= rd;
    write   <= wr;
    addr    <= a;
    data_in <= d;
    w_type  <= strb;
    @(negedge clk);
    if (pend_valid) begin
      check_cond(stall === 1'b1, "stall low on the first cycle after a strobe");
      while (stall === 1'b1) begin
        high_cycles++;
        @(negedge clk);
      end
      check_cond(high_cycles >= accept_delay, "stall fell before the acceptance delay");
      check_cond(high_cycles + 1 <= bound, "request took longer than its bound");
      // Stall drops in the R handshake cycle, data_out is live there
      if (pend_read) begin
        check_word(data_out, pend_exp, "read data");
        last_rd = pend_exp;
      end
    end else begin
      check_cond(stall === 1'b0, "stall high while idle");
      check_word(data_out, last_rd, "held read data");
    end
    // Strobe is taken in this cycle
    pend_valid = rd | wr;
    pend_read  = rd & ~wr;
    if (wr) begin
      model_write(a, d, strb);
    end else if (rd) begin
      pend_exp = model_read(a);
    end
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] strb);
    run_step(1'b0, 1'b1, a, d, strb);
  endtask

  task automatic read_word(input logic [31:0] a);
    run_step(1'b1, 1'b0, a, '0, '0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) run_step(1'b0, 1'b0, '0, '0, '0);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    rstn        = 1'b0;
    read        = 1'b0;
    write       = 1'b0;
    addr        = '0;
    data_in     = '0;
    w_type      = '0;
    pend_valid  = 1'b0;
    pend_read   = 1'b0;
    pend_exp    = '0;
    last_rd     = '0;
    check_count = 0;
    error_count = 0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;

    idle_cycles(4);

    for (int j = 0; j < 32; j++) begin
      write_word(slot_addr(j), fill_word(slot_addr(j)), 4'hF);
    end

    // Full word round trip, then hold on data_out
    write_word(32'h14, 32'hDEADBEEF, 4'hF);
    read_word(32'h14);
    idle_cycles(3);

    // Byte and halfword lanes over a known word
    write_word(32'h1C, 32'h11223344, 4'hF);
    write_word(32'h1C, 32'hAABBCCDD, 4'b0001);
    read_word(32'h1C);
    write_word(32'h1C, 32'h55667788, 4'b0100);
    read_word(32'h1C);
    write_word(32'h1C, 32'h99AABBCC, 4'b1100);
    read_word(32'h1C);
    write_word(32'h1C, 32'hF0E1D2C3, 4'b0011);
    read_word(32'h1C);
    idle_cycles(2);

    // Unmapped indices, two of them alias words 0 and 7 in the low bits
    write_word(32'h400, 32'h0BADF00D, 4'hF);
    write_word(32'h41C, 32'h0BADF00D, 4'hF);
    write_word(32'hFFFF_FFFC, 32'h0BADF00D, 4'hF);
    read_word(32'h400);
    read_word(32'h41C);
    read_word(32'hFFFF_FFFC);
    read_word(32'h0);
    read_word(32'h1C);
    idle_cycles(2);

    for (int n = 0; n < 300; n++) begin
      r = $random(seed);
      d = $random(seed);
      if (r[7:6] == 2'b00) begin
        a = $random(seed);
        a = {a[31:10] | 22'h1, a[9:2], 2'b00};
      end else begin
        a = slot_addr(int'(r[16:12]));
      end
      if (r[5:3] == 3'b000) idle_cycles(1);
      // Read strobe set along with write here at times
      if (r[0]) begin
        run_step(r[1], 1'b1, a, d, r[11:8]);
      end else begin
        read_word(a);
      end
    end
    idle_cycles(2);

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    master_state_t stuck;
    #(max_requests * write_bound * clk_period);
    stuck = dut.u_master.state;
    $display("Timeout: run did not finish after %0d time units, master in state %s",
             max_requests * write_bound * clk_period, stuck.name());
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: verilog/axi_if.sv
interface axi_if
  import axi_pkg::*;
();

  // Write address
  logic [axi_id_bits-1:0]   awid;
  logic [axi_addr_bits-1:0] awaddr;
  logic [axi_len_bits-1:0]  awlen;
  logic [axi_size_bits-1:0] awsize;
  axi_burst_t               awburst;
  logic                     awvalid;
  logic                     awready;

  // Write data
  logic [axi_data_bits-1:0] wdata;
  logic [axi_strb_bits-1:0] wstrb;
  logic                     wlast;
  logic                     wvalid;
  logic                     wready;

  // Write response
  logic [axi_id_bits-1:0]   bid;
  axi_resp_t                bresp;
  logic                     bvalid;
  logic                     bready;

  // Read address
  logic [axi_id_bits-1:0]   arid;
  logic [axi_addr_bits-1:0] araddr;
  logic [axi_len_bits-1:0]  arlen;
  logic [axi_size_bits-1:0] arsize;
  axi_burst_t               arburst;
  logic                     arvalid;
  logic                     arready;

  // Read data
  logic [axi_id_bits-1:0]   rid;
  logic [axi_data_bits-1:0] rdata;
  axi_resp_t                rresp;
  logic                     rlast;
  logic                     rvalid;
  logic                     rready;

  modport master (
    output awid, awaddr, awlen, awsize, awburst, awvalid,
    output wdata, wstrb, wlast, wvalid,
    output bready,
    output arid, araddr, arlen, arsize, arburst, arvalid,
    output rready,
    input  awready, wready, bid, bresp, bvalid, arready,
    input  rid, rdata, rresp, rlast, rvalid
  );

  modport slave (
    input  awid, awaddr, awlen, awsize, awburst, awvalid,
    input  wdata, wstrb, wlast, wvalid,
    input  bready,
    input  arid, araddr, arlen, arsize, arburst, arvalid,
    input  rready,
    output awready, wready, bid, bresp, bvalid, arready,
    output rid, rdata, rresp, rlast, rvalid
  );

endinterface

// File: verilog/axi_master.sv
module axi_master
  import axi_pkg::*;
  import master_pkg::*;
(
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     read,
  input  logic                     write,
  input  logic [axi_addr_bits-1:0] addr,
  input  logic [axi_data_bits-1:0] data_in,
  input  logic [axi_strb_bits-1:0] w_type,
  output logic [axi_data_bits-1:0] data_out,
  output logic                     stall,
  axi_if.master                    bus
);

  // One full data word per beat
  localparam logic [axi_size_bits-1:0] size_word = axi_size_bits'($clog2(axi_strb_bits));

  master_state_t state, state_next, req_state;

  logic [axi_addr_bits-1:0] addr_q;
  logic [axi_data_bits-1:0] wdata_q;
  logic [axi_strb_bits-1:0] wstrb_q;
  logic [axi_data_bits-1:0] rdata_q;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;

  assign ar_hs = bus.arvalid & bus.arready;
  assign r_hs  = bus.rvalid & bus.rready;
  assign aw_hs = bus.awvalid & bus.awready;
  assign w_hs  = bus.wvalid & bus.wready;
  assign b_hs  = bus.bvalid & bus.bready;

  // Write wins over read when both strobes are set
  assign req_state = write ? AW : (read ? AR : IDLE);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: state_next = req_state;
      AR:   state_next = ar_hs ? R : AR;
      R:    state_next = r_hs ? req_state : R;
      AW:   state_next = aw_hs ? W : AW;
      W: begin
        if (w_hs) begin
          state_next = b_hs ? IDLE : B;
        end
      end
      B:    state_next = b_hs ? req_state : B;
      default: state_next = IDLE;
    endcase
  end

  // Request fields are only valid on the strobe cycle
  always_ff @(posedge clk) begin
    if ((state_next == AR && state != AR) || (state_next == AW && state != AW)) begin
      addr_q <= addr;
    end
    if (state_next == AW && state != AW) begin
      wdata_q <= data_in;
      wstrb_q <= w_type;
    end
  end

  // Last read word with live data bypassed during the handshake
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_q <= '0;
    end else if (r_hs) begin
      rdata_q <= bus.rdata;
    end
  end

  assign data_out = r_hs ? bus.rdata : rdata_q;

  // Fixed single-beat attributes
  assign bus.awid    = '0;
  assign bus.awaddr  = addr_q;
  assign bus.awlen   = '0;
  assign bus.awsize  = size_word;
  assign bus.awburst = INCR;
  assign bus.wdata   = wdata_q;
  assign bus.wstrb   = wstrb_q;
  assign bus.wlast   = 1'b1;
  assign bus.arid    = '0;
  assign bus.araddr  = addr_q;
  assign bus.arlen   = '0;
  assign bus.arsize  = size_word;
  assign bus.arburst = INCR;

  always_comb begin
    bus.awvalid = 1'b0;
    bus.wvalid  = 1'b0;
    bus.bready  = 1'b0;
    bus.arvalid = 1'b0;
    bus.rready  = 1'b0;
    stall       = 1'b0;
    case (state)
      AR: begin
        bus.arvalid = 1'b1;
        stall       = 1'b1;
      end
      R: begin
        bus.rready = 1'b1;
      end
      AW: begin
        bus.awvalid = 1'b1;
        stall       = 1'b1;
      end
      W: begin
        // Response may be taken in the same cycle as the data
        bus.wvalid = 1'b1;
        bus.bready = 1'b1;
        stall      = 1'b1;
      end
      B: begin
        bus.bready = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/axi_pkg.sv
package axi_pkg;

  // Bus field widths
  localparam int axi_addr_bits = 32;
  localparam int axi_data_bits = 32;
  localparam int axi_strb_bits = axi_data_bits / 8;
  localparam int axi_id_bits   = 4;
  localparam int axi_len_bits  = 8;
  localparam int axi_size_bits = 3;

  // AxBURST encodings
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_t;

  // xRESP encodings
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_t;

endpackage

// File: verilog/axi_sram_slave.sv
module axi_sram_slave
  import axi_pkg::*;
#(
  parameter int mem_words    = 256,
  parameter int accept_delay = 2
) (
  input  logic clk,
  input  logic rstn,
  axi_if.slave bus
);

  localparam int lane_bits = $clog2(axi_strb_bits);
  localparam int word_bits = axi_addr_bits - lane_bits;
  localparam int idx_bits  = $clog2(mem_words);
  localparam int cnt_bits  = $clog2(accept_delay + 2);

  // Channel slots for the acceptance counters
  localparam int ch_aw = 0;
  localparam int ch_w  = 1;
  localparam int ch_ar = 2;

  logic [axi_data_bits-1:0] mem [mem_words];

  logic [2:0]               chan_wait;
  logic [2:0]               chan_rdy;
  logic [2:0][cnt_bits-1:0] chan_cnt;

  logic                     aw_got;
  logic                     w_got;
  logic [axi_addr_bits-1:0] awaddr_q;
  logic [axi_id_bits-1:0]   awid_q;
  logic [axi_data_bits-1:0] wdata_q;
  logic [axi_strb_bits-1:0] wstrb_q;

  logic                     aw_hs;
  logic                     w_hs;
  logic                     ar_hs;
  logic                     r_hs;
  logic                     b_hs;
  logic                     commit;
  logic [axi_addr_bits-1:0] wr_addr;
  logic [axi_data_bits-1:0] wr_data;
  logic [axi_strb_bits-1:0] wr_strb;

  function automatic logic is_mapped(input logic [axi_addr_bits-1:0] a);
    return a[axi_addr_bits-1:lane_bits] < word_bits'(mem_words);
  endfunction

  function automatic logic [idx_bits-1:0] word_idx(input logic [axi_addr_bits-1:0] a);
    return a[lane_bits +: idx_bits];
  endfunction

  // Busy channels refuse new requests until their response drains
  assign chan_wait[ch_aw] = bus.awvalid & ~aw_got & ~bus.bvalid;
  assign chan_wait[ch_w]  = bus.wvalid & ~w_got & ~bus.bvalid;
  assign chan_wait[ch_ar] = bus.arvalid & ~bus.rvalid;

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      chan_rdy[c] = chan_wait[c] && (chan_cnt[c] == cnt_bits'(accept_delay));
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      chan_cnt <= '0;
    end else begin
      for (int c = 0; c < 3; c++) begin
        if (!chan_wait[c] || chan_rdy[c]) begin
          chan_cnt[c] <= '0;
        end else begin
          chan_cnt[c] <= chan_cnt[c] + 1'b1;
        end
      end
    end
  end

  assign bus.awready = chan_rdy[ch_aw];
  assign bus.wready  = chan_rdy[ch_w];
  assign bus.arready = chan_rdy[ch_ar];

  assign aw_hs = bus.awvalid & bus.awready;
  assign w_hs  = bus.wvalid & bus.wready;
  assign ar_hs = bus.arvalid & bus.arready;
  assign r_hs  = bus.rvalid & bus.rready;
  assign b_hs  = bus.bvalid & bus.bready;

  // Write goes through once both halves are in, either order
  assign commit  = (aw_got | aw_hs) & (w_got | w_hs);
  assign wr_addr = aw_got ? awaddr_q : bus.awaddr;
  assign wr_data = w_got ? wdata_q : bus.wdata;
  assign wr_strb = w_got ? wstrb_q : bus.wstrb;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      bus.bvalid <= 1'b0;
    end else begin
      if (commit) begin
        aw_got     <= 1'b0;
        w_got      <= 1'b0;
        bus.bvalid <= 1'b1;
      end else begin
        if (aw_hs) aw_got <= 1'b1;
        if (w_hs) w_got <= 1'b1;
        if (b_hs) bus.bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      awaddr_q <= bus.awaddr;
      awid_q   <= bus.awid;
    end
    if (w_hs) begin
      wdata_q <= bus.wdata;
      wstrb_q <= bus.wstrb;
    end
    if (commit) begin
      bus.bid   <= aw_got ? awid_q : bus.awid;
      bus.bresp <= is_mapped(wr_addr) ? OKAY : SLVERR;
      // Unmapped writes are dropped
      if (is_mapped(wr_addr)) begin
        for (int i = 0; i < axi_strb_bits; i++) begin
          if (wr_strb[i]) mem[word_idx(wr_addr)][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bus.rvalid <= 1'b0;
    end else if (ar_hs) begin
      bus.rvalid <= 1'b1;
    end else if (r_hs) begin
      bus.rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      bus.rid   <= bus.arid;
      bus.rdata <= is_mapped(bus.araddr) ? mem[word_idx(bus.araddr)] : '0;
      bus.rresp <= is_mapped(bus.araddr) ? OKAY : SLVERR;
    end
  end

  assign bus.rlast = bus.rvalid;

endmodule

// File: verilog/cpu_mem_sys.sv
module cpu_mem_sys
  import axi_pkg::*;
#(
  parameter int mem_words    = 256,
  parameter int accept_delay = 2
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     read,
  input  logic                     write,
  input  logic [axi_addr_bits-1:0] addr,
  input  logic [axi_data_bits-1:0] data_in,
  input  logic [axi_strb_bits-1:0] w_type,
  output logic [axi_data_bits-1:0] data_out,
  output logic                     stall
);

  axi_if bus ();

  axi_master u_master (
    .clk      (clk),
    .rstn     (rstn),
    .read     (read),
    .write    (write),
    .addr     (addr),
    .data_in  (data_in),
    .w_type   (w_type),
    .data_out (data_out),
    .stall    (stall),
    .bus      (bus.master)
  );

  axi_sram_slave #(
    .mem_words    (mem_words),
    .accept_delay (accept_delay)
  ) u_sram (
    .clk  (clk),
    .rstn (rstn),
    .bus  (bus.slave)
  );

endmodule

// File: verilog/master_pkg.sv
package master_pkg;

  // Transaction controller states
  // AR/R for reads, AW/W/B for writes
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    AR   = 3'd1,
    R    = 3'd2,
    AW   = 3'd3,
    W    = 3'd4,
    B    = 3'd5
  } master_state_t;

endpackage
